/* files.f */
+incdir+sim
verilog/exec_pkg.sv
verilog/int_alu.sv
verilog/mult_pipe.sv
verilog/issue_route.sv
verilog/cdb_arbiter.sv
verilog/exec_unit.sv
sim/exec_unit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the execute stage testbench with Verilator and runs it.
# The exit status is nonzero when the build or any check fails.

cd "$(dirname "$0")" || exit 1

verilator --binary -f files.f --top-module exec_unit_tb -o exec_unit_tb \
	&& ./obj_dir/exec_unit_tb \
	|| exit 1

/* sim/exec_ref.svh */
// Reference model for the execute stage testbench.
// ref_result gives the expected broadcast value of an operation;
// lfsr_bits draws random bits from a 16-bit Fibonacci LFSR.

`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

localparam logic [15:0] LFSR_SEED = 16'd53;

function automatic exec_pkg::word_t ref_result(input exec_pkg::word_t a,
		input exec_pkg::word_t b_reg, input exec_pkg::inst_t inst);
	exec_pkg::word_t b;
	logic [6:0] fn;
	b = inst[exec_pkg::LIT_FLAG_BIT] ? {56'd0, inst[exec_pkg::LIT_MSB:exec_pkg::LIT_LSB]} : b_reg;
	fn = inst[exec_pkg::FUNC_MSB:exec_pkg::FUNC_LSB];
	case (fn)
		exec_pkg::ADDQ: return a + b;
		exec_pkg::SUBQ: return a - b;
		exec_pkg::CMPEQ: return {63'd0, a == b};
		exec_pkg::CMPULT: return {63'd0, a < b};
		exec_pkg::CMPULE: return {63'd0, a <= b};
		exec_pkg::CMPLT: return {63'd0, $signed(a) < $signed(b)};
		exec_pkg::CMPLE: return {63'd0, $signed(a) <= $signed(b)};
		exec_pkg::AND: return a & b;
		exec_pkg::BIC: return a & ~b;
		exec_pkg::BIS: return a | b;
		exec_pkg::ORNOT: return a | ~b;
		exec_pkg::XOR: return a ^ b;
		exec_pkg::EQV: return ~(a ^ b);
		exec_pkg::SRL: return a >> b[5:0];
		exec_pkg::SLL: return a << b[5:0];
		exec_pkg::SRA: return exec_pkg::word_t'($signed(a) >>> b[5:0]);
		exec_pkg::MULQ: return a * b; // low 64 bits.
		default: return exec_pkg::POISON_WORD;
	endcase
endfunction

// taps 16, 14, 13, 11; one step per bit taken
function automatic exec_pkg::word_t lfsr_bits(inout logic [15:0] state, input int n);
	exec_pkg::word_t w;
	w = '0;
	for (int i = 0; i < n; i++) begin
		w = {w[62:0], state[15]};
		state = {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	end
	return w;
endfunction

`endif

/* sim/exec_unit_tb.sv */
// Directed testbench for the integer execute stage.
// Each test task issues operations through issue_op, which records the expected
// broadcast; a monitor on the falling clock edge pops and checks every result.

`timescale 1ns/1ns
`default_nettype none

module exec_unit_tb;

	`include "exec_ref.svh"

	localparam int MUL_STAGES = 4; // DUT default.
	localparam int CYCLE_LIMIT = 3000; // roughly four times the whole run.
	localparam int DRAIN_LIMIT = 32;
	localparam exec_pkg::inst_t INST_FILL = 32'hffe0_001f; // unused fields set.
	localparam logic [6:0] ALU_FUNCS [16] = '{
		exec_pkg::ADDQ, exec_pkg::SUBQ, exec_pkg::CMPEQ, exec_pkg::CMPULT,
		exec_pkg::CMPULE, exec_pkg::CMPLT, exec_pkg::CMPLE, exec_pkg::AND,
		exec_pkg::BIC, exec_pkg::BIS, exec_pkg::ORNOT, exec_pkg::XOR,
		exec_pkg::EQV, exec_pkg::SRL, exec_pkg::SLL, exec_pkg::SRA
	};
	// sign-boundary operand pairs
	localparam exec_pkg::word_t PAIR_A [4] = '{64'h7fff_ffff_ffff_ffff,
		64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff, 64'h0000_0000_0000_0005};
	localparam exec_pkg::word_t PAIR_B [4] = '{64'h8000_0000_0000_0000,
		64'h7fff_ffff_ffff_ffff, 64'h0000_0000_0000_0001, 64'h0000_0000_0000_0005};

	typedef struct packed {
		exec_pkg::word_t value;
		exec_pkg::prf_tag_t tag;
		exec_pkg::rob_idx_t rob;
		int due; // broadcast cycle, negative when not fixed.
	} expect_t;

	logic clk;
	logic rst;
	logic start;
	exec_pkg::word_t opa;
	exec_pkg::word_t opb;
	exec_pkg::inst_t inst;
	exec_pkg::prf_tag_t dest_tag;
	exec_pkg::rob_idx_t rob_idx;
	logic ready;
	logic cdb_valid;
	exec_pkg::word_t cdb_value;
	exec_pkg::prf_tag_t cdb_tag;
	exec_pkg::rob_idx_t cdb_rob;

	expect_t alu_q [$];
	expect_t mul_q [$];
	int cycles;
	int alu_n;
	int mul_n;
	int op_n;
	int ready_low_cycles;
	logic [15:0] lfsr;

	exec_unit dut0 (
		.clk(clk), .rst(rst), .start_i(start), .opa_i(opa), .opb_i(opb), .inst_i(inst),
		.dest_tag_i(dest_tag), .rob_idx_i(rob_idx), .ready_o(ready),
		.cdb_valid_o(cdb_valid), .cdb_value_o(cdb_value), .cdb_tag_o(cdb_tag),
		.cdb_rob_idx_o(cdb_rob)
	);

	always #50 clk = ~clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic compare_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			$display("MISMATCH at %0t ns: %s actual %h expected %h", $time, name, actual, expected);
			fail_run("value check failed");
		end
	endtask

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) fail_run("timeout: cycle limit reached before the tests ended");
	end

	// tag bit 6 marks a multiplier operation
	always @(negedge clk) begin : cdb_monitor
		expect_t e;
		if (!rst && !ready) ready_low_cycles = ready_low_cycles + 1;
		if (!rst && cdb_valid) begin
			if ((cdb_tag[6] && mul_q.size() == 0) || (!cdb_tag[6] && alu_q.size() == 0)) begin
				fail_run($sformatf("broadcast with tag %0d matches no pending operation", cdb_tag));
			end else begin
				if (cdb_tag[6]) e = mul_q.pop_front();
				else e = alu_q.pop_front();
				compare_value("cdb_tag_o", 64'(cdb_tag), 64'(e.tag));
				compare_value("cdb_rob_idx_o", 64'(cdb_rob), 64'(e.rob));
				compare_value("cdb_value_o", cdb_value, e.value);
				if (e.due >= 0) compare_value("broadcast cycle", 64'(cycles), 64'(e.due));
			end
		end
	end

	function automatic exec_pkg::inst_t make_inst(input logic [6:0] fn, input logic use_lit,
			input logic [7:0] lit);
		exec_pkg::inst_t w;
		w = INST_FILL;
		w[exec_pkg::FUNC_MSB:exec_pkg::FUNC_LSB] = fn;
		w[exec_pkg::LIT_FLAG_BIT] = use_lit;
		w[exec_pkg::LIT_MSB:exec_pkg::LIT_LSB] = lit;
		return w;
	endfunction

	function automatic exec_pkg::word_t rand_word();
		return lfsr_bits(lfsr, 64);
	endfunction

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#5;
			start = 1'b0;
		end
	endtask

	// waits for ready, drives one start and records the expected broadcast
	task automatic issue_op(input exec_pkg::word_t a, input exec_pkg::word_t b,
			input exec_pkg::inst_t in, input int delay);
		expect_t e;
		logic is_mul;
		@(posedge clk);
		#5;
		start = 1'b0;
		while (!ready) begin
			@(posedge clk);
			#5;
		end
		is_mul = in[exec_pkg::FUNC_MSB:exec_pkg::FUNC_LSB] == exec_pkg::MULQ;
		e.value = ref_result(a, b, in);
		e.tag = is_mul ? 7'(64 + mul_n % 64) : 7'(alu_n % 64);
		e.rob = 5'(op_n % 32);
		e.due = delay < 0 ? -1 : cycles + delay;
		start = 1'b1;
		opa = a;
		opb = b;
		inst = in;
		dest_tag = e.tag;
		rob_idx = e.rob;
		if (is_mul) begin
			mul_q.push_back(e);
			mul_n++;
		end else begin
			alu_q.push_back(e);
			alu_n++;
		end
		op_n++;
	endtask

	task automatic drain();
		idle(1);
		for (int i = 0; i < DRAIN_LIMIT; i++) begin
			if (alu_q.size() == 0 && mul_q.size() == 0) break;
			idle(1);
		end
		if (alu_q.size() != 0 || mul_q.size() != 0) fail_run("results still pending after drain");
	endtask

	task automatic single_op(input exec_pkg::word_t a, input exec_pkg::word_t b,
			input exec_pkg::inst_t in, input int delay);
		issue_op(a, b, in, delay);
		drain();
	endtask

	task automatic alu_function_sweep();
		compare_value("ready_o", 64'(ready), 64'd1);
		compare_value("cdb_valid_o", 64'(cdb_valid), 64'd0);
		for (int f = 0; f < 16; f++)
			for (int p = 0; p < 4; p++)
				single_op(PAIR_A[p], PAIR_B[p], make_inst(ALU_FUNCS[f], 1'b0, 8'h00), 2);
	endtask

	task automatic literal_and_poison();
		single_op(64'h0123_4567_89ab_cdef, '1, make_inst(exec_pkg::ADDQ, 1'b1, 8'hff), 2);
		single_op(64'd0, 64'd0, make_inst(exec_pkg::SUBQ, 1'b1, 8'h01), 2);
		single_op(64'h2a, 64'd7, make_inst(exec_pkg::CMPEQ, 1'b1, 8'h2a), 2);
		single_op(64'h10, 64'd0, make_inst(exec_pkg::CMPULT, 1'b1, 8'h80), 2);
		single_op('1, 64'd5, make_inst(exec_pkg::CMPULT, 1'b1, 8'h01), 2);
		single_op('1, '1, make_inst(exec_pkg::CMPLT, 1'b1, 8'h80), 2); // literal is positive.
		single_op(64'd1, 64'd0, make_inst(exec_pkg::SLL, 1'b1, 8'h3f), 2);
		single_op('1, 64'd0, make_inst(exec_pkg::SRL, 1'b1, 8'hc4), 2);
		single_op(64'd3, 64'd4, make_inst(7'h00, 1'b0, 8'h00), 2);
		single_op(64'd3, 64'd4, make_inst(7'h7f, 1'b1, 8'h11), 2);
		single_op(64'd3, 64'd4, make_inst(7'h41, 1'b0, 8'h00), 2);
	endtask

	task automatic shift_amounts();
		exec_pkg::word_t amts [5];
		exec_pkg::word_t vals [2];
		logic [6:0] fns [3];
		amts = '{64'd0, 64'd1, 64'd63, 64'h45, 64'hffff_ffff_ffff_ffbe};
		vals = '{64'hf0f0_0000_1234_5678, 64'h0f0f_0000_1234_5678};
		fns = '{exec_pkg::SRL, exec_pkg::SLL, exec_pkg::SRA};
		foreach (fns[f])
			foreach (vals[v])
				foreach (amts[s])
					single_op(vals[v], amts[s], make_inst(fns[f], 1'b0, 8'h00), 2);
	endtask

	task automatic multiply_stream();
		exec_pkg::word_t a;
		exec_pkg::word_t b;
		for (int i = 0; i < 8; i++) begin
			a = rand_word();
			b = rand_word();
			single_op(a, b, make_inst(exec_pkg::MULQ, 1'b0, 8'h00), MUL_STAGES + 1);
		end
		a = rand_word();
		single_op(a, 64'd9, make_inst(exec_pkg::MULQ, 1'b1, 8'hd3), MUL_STAGES + 1);
		for (int i = 0; i < 6; i++) begin // one result per cycle.
			a = rand_word();
			b = rand_word();
			issue_op(a, b, make_inst(exec_pkg::MULQ, 1'b0, 8'h00), MUL_STAGES + 1);
		end
		drain();
	endtask

	// ALU issued MUL_STAGES-1 cycles after MULQ finishes in the same cycle
	task automatic mul_alu_collision();
		exec_pkg::word_t a;
		exec_pkg::word_t b;
		for (int i = 0; i < 3; i++) begin
			a = rand_word();
			b = rand_word();
			issue_op(a, b, make_inst(exec_pkg::MULQ, 1'b0, 8'h00), MUL_STAGES + 1);
			idle(MUL_STAGES - 2);
			a = rand_word();
			b = rand_word();
			issue_op(a, b, make_inst(ALU_FUNCS[4'(lfsr_bits(lfsr, 4))], 1'b0, 8'h00), 3);
			drain();
		end
	endtask

	// alternating runs of MULQ and ALU ops keep the queue under pressure
	task automatic queue_backpressure();
		exec_pkg::word_t a;
		exec_pkg::word_t b;
		exec_pkg::inst_t in;
		logic mul_run;
		int run_len;
		int n_ops;
		ready_low_cycles = 0;
		mul_run = 1'b1;
		n_ops = 0;
		while (n_ops < 160) begin
			run_len = 32'(lfsr_bits(lfsr, 2)) + 1;
			for (int i = 0; i < run_len; i++) begin
				a = rand_word();
				b = rand_word();
				if (mul_run) in = make_inst(exec_pkg::MULQ, 1'b0, 8'h00);
				else in = make_inst(ALU_FUNCS[4'(lfsr_bits(lfsr, 4))],
					1'(lfsr_bits(lfsr, 1)), 8'(lfsr_bits(lfsr, 8)));
				issue_op(a, b, in, -1);
				n_ops++;
			end
			mul_run = !mul_run;
		end
		drain();
		if (ready_low_cycles == 0) fail_run("ready_o never dropped under back-pressure");
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		opa = '0;
		opb = '0;
		inst = '0;
		dest_tag = '0;
		rob_idx = '0;
		cycles = 0;
		alu_n = 0;
		mul_n = 0;
		op_n = 0;
		ready_low_cycles = 0;
		lfsr = LFSR_SEED;
		repeat (2) @(posedge clk);
		#5;
		rst = 1'b0;
		alu_function_sweep();
		literal_and_poison();
		shift_amounts();
		multiply_stream();
		mul_alu_collision();
		queue_backpressure();
		idle(4);
		if (alu_q.size() != 0 || mul_q.size() != 0) begin
			fail_run("expected broadcasts missing at the end of the run");
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* verilog/cdb_arbiter.sv */
// Completion arbiter driving the registered result broadcast bus.
// Multiplier results always take the bus; ALU results wait in an in-order
// queue and leave on cycles without a multiplier result.
// q_room_o stays high while at least two queue slots are free.

`timescale 1ns/1ns
`default_nettype none

module cdb_arbiter #(
	parameter int ALU_Q_DEPTH = 4
) (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     alu_done_i,
	input  wire exec_pkg::word_t    alu_value_i,
	input  wire exec_pkg::prf_tag_t alu_tag_i,
	input  wire exec_pkg::rob_idx_t alu_rob_i,
	input  wire                     mul_done_i,
	input  wire exec_pkg::word_t    mul_value_i,
	input  wire exec_pkg::prf_tag_t mul_tag_i,
	input  wire exec_pkg::rob_idx_t mul_rob_i,
	output logic                    q_room_o,
	output logic                    cdb_valid_o,
	output exec_pkg::word_t         cdb_value_o,
	output exec_pkg::prf_tag_t      cdb_tag_o,
	output exec_pkg::rob_idx_t      cdb_rob_idx_o
);

	localparam int PTR_W = $clog2(ALU_Q_DEPTH);
	localparam int CNT_W = PTR_W + 1;
	localparam logic [CNT_W-1:0] ROOM_LIMIT = CNT_W'(ALU_Q_DEPTH - 2);

	exec_pkg::word_t q_value [ALU_Q_DEPTH];
	exec_pkg::prf_tag_t q_tag [ALU_Q_DEPTH];
	exec_pkg::rob_idx_t q_rob [ALU_Q_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic q_empty;
	logic bypass;
	logic wr_en;
	logic rd_en;

	assign q_empty = count == '0;
	assign bypass = q_empty && alu_done_i && !mul_done_i; // straight to the bus.
	assign wr_en = alu_done_i && !bypass;
	assign rd_en = !q_empty && !mul_done_i;
	assign q_room_o = count <= ROOM_LIMIT;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) wr_ptr <= wr_ptr + PTR_W'(1); // wraps, depth is a power of two.
			if (rd_en) rd_ptr <= rd_ptr + PTR_W'(1);
			case ({wr_en, rd_en})
				2'b10: count <= count + CNT_W'(1);
				2'b01: count <= count - CNT_W'(1);
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			q_value[wr_ptr] <= alu_value_i;
			q_tag[wr_ptr] <= alu_tag_i;
			q_rob[wr_ptr] <= alu_rob_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cdb_valid_o <= 1'b0;
		end else begin
			cdb_valid_o <= mul_done_i || rd_en || bypass;
		end
	end

	// multiplier first, then the queue head, then a fresh ALU result
	always_ff @(posedge clk) begin
		if (mul_done_i) begin
			cdb_value_o <= mul_value_i;
			cdb_tag_o <= mul_tag_i;
			cdb_rob_idx_o <= mul_rob_i;
		end else if (rd_en) begin
			cdb_value_o <= q_value[rd_ptr];
			cdb_tag_o <= q_tag[rd_ptr];
			cdb_rob_idx_o <= q_rob[rd_ptr];
		end else if (bypass) begin
			cdb_value_o <= alu_value_i;
			cdb_tag_o <= alu_tag_i;
			cdb_rob_idx_o <= alu_rob_i;
		end
	end

endmodule

`default_nettype wire

/* verilog/exec_pkg.sv */
// Shared types, function codes and instruction fields for the integer execute stage.
// Every module refers to these through exec_pkg:: scoped names.
// The function codes are this core's own numbering and not Alpha encodings.

`default_nettype none

package exec_pkg;

	typedef logic [63:0] word_t; // operand and result word.
	typedef logic [6:0] prf_tag_t; // physical register tag.
	typedef logic [4:0] rob_idx_t; // reorder buffer slot.
	typedef logic [31:0] inst_t;

	// function field encodings
	typedef enum logic [6:0] {
		ADDQ   = 7'h20,
		SUBQ   = 7'h21,
		CMPEQ  = 7'h28,
		CMPULT = 7'h29,
		CMPULE = 7'h2a,
		CMPLT  = 7'h2b,
		CMPLE  = 7'h2c,
		AND    = 7'h30,
		BIC    = 7'h31,
		BIS    = 7'h32,
		ORNOT  = 7'h33,
		XOR    = 7'h34,
		EQV    = 7'h35,
		SRL    = 7'h38,
		SLL    = 7'h39,
		SRA    = 7'h3a,
		MULQ   = 7'h40 // only code routed to the multiplier.
	} func_e;

	// instruction word layout
	localparam int FUNC_LSB = 5;
	localparam int FUNC_MSB = 11;
	localparam int LIT_FLAG_BIT = 12; // second operand is the literal.
	localparam int LIT_LSB = 13;
	localparam int LIT_MSB = 20;

	// result returned for a function code outside the list
	localparam word_t POISON_WORD = 64'hdead_beef_baad_beef;

endpackage

`default_nettype wire

/* verilog/exec_unit.sv */
// Top of the integer execute stage.
// Routes issued operations to the ALU or the multiplier and merges both result
// streams onto one broadcast bus. Issue only while ready_o is high.

`timescale 1ns/1ns
`default_nettype none

module exec_unit #(
	parameter int MUL_STAGES = 4,
	parameter int ALU_Q_DEPTH = 4
) (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     start_i,
	input  wire exec_pkg::word_t    opa_i,
	input  wire exec_pkg::word_t    opb_i,
	input  wire exec_pkg::inst_t    inst_i,
	input  wire exec_pkg::prf_tag_t dest_tag_i,
	input  wire exec_pkg::rob_idx_t rob_idx_i,
	output logic                    ready_o,
	output logic                    cdb_valid_o,
	output exec_pkg::word_t         cdb_value_o,
	output exec_pkg::prf_tag_t      cdb_tag_o,
	output exec_pkg::rob_idx_t      cdb_rob_idx_o
);

	logic alu_start;
	logic mul_start;
	logic q_room;
	logic alu_done;
	exec_pkg::word_t alu_value;
	exec_pkg::prf_tag_t alu_tag;
	exec_pkg::rob_idx_t alu_rob;
	logic mul_done;
	exec_pkg::word_t mul_value;
	exec_pkg::prf_tag_t mul_tag;
	exec_pkg::rob_idx_t mul_rob;

	issue_route route0 (
		.start_i(start_i), .inst_i(inst_i), .q_room_i(q_room),
		.alu_start_o(alu_start), .mul_start_o(mul_start), .ready_o(ready_o)
	);

	int_alu alu0 (
		.clk(clk), .rst(rst), .start_i(alu_start),
		.opa_i(opa_i), .opb_i(opb_i), .inst_i(inst_i),
		.dest_tag_i(dest_tag_i), .rob_idx_i(rob_idx_i),
		.result_o(alu_value), .dest_tag_o(alu_tag), .rob_idx_o(alu_rob), .done_o(alu_done)
	);

	mult_pipe #(.MUL_STAGES(MUL_STAGES)) mul0 (
		.clk(clk), .rst(rst), .start_i(mul_start),
		.opa_i(opa_i), .opb_i(opb_i), .inst_i(inst_i),
		.dest_tag_i(dest_tag_i), .rob_idx_i(rob_idx_i),
		.product_o(mul_value), .dest_tag_o(mul_tag), .rob_idx_o(mul_rob), .done_o(mul_done)
	);

	cdb_arbiter #(.ALU_Q_DEPTH(ALU_Q_DEPTH)) arb0 (
		.clk(clk), .rst(rst),
		.alu_done_i(alu_done), .alu_value_i(alu_value),
		.alu_tag_i(alu_tag), .alu_rob_i(alu_rob),
		.mul_done_i(mul_done), .mul_value_i(mul_value),
		.mul_tag_i(mul_tag), .mul_rob_i(mul_rob),
		.q_room_o(q_room), .cdb_valid_o(cdb_valid_o), .cdb_value_o(cdb_value_o),
		.cdb_tag_o(cdb_tag_o), .cdb_rob_idx_o(cdb_rob_idx_o)
	);

endmodule

`default_nettype wire

/* verilog/int_alu.sv */
// Single-cycle integer ALU of the execute stage.
// A start pulse registers the result together with the destination tag and
// reorder-buffer index; done_o follows one cycle later for one cycle.

`timescale 1ns/1ns
`default_nettype none

module int_alu (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 start_i,
	input  wire exec_pkg::word_t    opa_i,
	input  wire exec_pkg::word_t    opb_i,
	input  wire exec_pkg::inst_t    inst_i,
	input  wire exec_pkg::prf_tag_t dest_tag_i,
	input  wire exec_pkg::rob_idx_t rob_idx_i,
	output exec_pkg::word_t         result_o,
	output exec_pkg::prf_tag_t      dest_tag_o,
	output exec_pkg::rob_idx_t      rob_idx_o,
	output logic                    done_o
);

	exec_pkg::word_t lit_word;
	exec_pkg::word_t opb;
	exec_pkg::word_t result_nxt;
	exec_pkg::func_e func;
	logic [5:0] shamt;

	assign lit_word = exec_pkg::word_t'(inst_i[exec_pkg::LIT_MSB:exec_pkg::LIT_LSB]);
	assign opb = inst_i[exec_pkg::LIT_FLAG_BIT] ? lit_word : opb_i; // literal wins.
	assign func = exec_pkg::func_e'(inst_i[exec_pkg::FUNC_MSB:exec_pkg::FUNC_LSB]);
	assign shamt = opb[5:0]; // low 6 bits only.

	always_comb begin
		case (func)
			exec_pkg::ADDQ:
				result_nxt = opa_i + opb;
			exec_pkg::SUBQ:
				result_nxt = opa_i - opb;
			exec_pkg::CMPEQ:
				result_nxt = {63'd0, opa_i == opb};
			exec_pkg::CMPULT:
				result_nxt = {63'd0, opa_i < opb};
			exec_pkg::CMPULE:
				result_nxt = {63'd0, opa_i <= opb};
			exec_pkg::CMPLT:
				result_nxt = {63'd0, $signed(opa_i) < $signed(opb)};
			exec_pkg::CMPLE:
				result_nxt = {63'd0, $signed(opa_i) <= $signed(opb)};
			exec_pkg::AND:
				result_nxt = opa_i & opb;
			exec_pkg::BIC:
				result_nxt = opa_i & ~opb;
			exec_pkg::BIS:
				result_nxt = opa_i | opb;
			exec_pkg::ORNOT:
				result_nxt = opa_i | ~opb;
			exec_pkg::XOR:
				result_nxt = opa_i ^ opb;
			exec_pkg::EQV:
				result_nxt = opa_i ^ ~opb;
			exec_pkg::SRL:
				result_nxt = opa_i >> shamt;
			exec_pkg::SLL:
				result_nxt = opa_i << shamt;
			exec_pkg::SRA:
				result_nxt = exec_pkg::word_t'($signed(opa_i) >>> shamt); // sign fill.
			default:
				result_nxt = exec_pkg::POISON_WORD; // MULQ lands here too, never issued.
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			done_o <= 1'b0;
		end else begin
			done_o <= start_i; // one-cycle pulse.
		end
	end

	// payload only moves on a start
	always_ff @(posedge clk) begin
		if (start_i) begin
			result_o <= result_nxt;
			dest_tag_o <= dest_tag_i;
			rob_idx_o <= rob_idx_i;
		end
	end

endmodule

`default_nettype wire

/* verilog/issue_route.sv */
// Issue router of the execute stage.
// Steers each start pulse to the multiplier for MULQ and to the ALU otherwise,
// and reports issue readiness from the result queue room.

`timescale 1ns/1ns
`default_nettype none

module issue_route (
	input  wire                  start_i,
	input  wire exec_pkg::inst_t inst_i,
	input  wire                  q_room_i,
	output logic                 alu_start_o,
	output logic                 mul_start_o,
	output logic                 ready_o
);

	logic is_mul;

	// only the function field decides the unit
	assign is_mul = inst_i[exec_pkg::FUNC_MSB:exec_pkg::FUNC_LSB] == exec_pkg::MULQ;

	assign mul_start_o = start_i && is_mul;
	assign alu_start_o = start_i && !is_mul; // unknown codes go to the ALU.

	// room for the new result plus the one in flight
	assign ready_o = q_room_i;

endmodule

`default_nettype wire

/* verilog/mult_pipe.sv */
// Pipelined 64-bit multiplier returning the low product word.
// Each of the MUL_STAGES stages adds one slice of partial products, so a new
// operation can enter every cycle and done_o rises MUL_STAGES cycles after start.

`timescale 1ns/1ns
`default_nettype none

module mult_pipe #(
	parameter int MUL_STAGES = 4
) (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     start_i,
	input  wire exec_pkg::word_t    opa_i,
	input  wire exec_pkg::word_t    opb_i,
	input  wire exec_pkg::inst_t    inst_i,
	input  wire exec_pkg::prf_tag_t dest_tag_i,
	input  wire exec_pkg::rob_idx_t rob_idx_i,
	output exec_pkg::word_t         product_o,
	output exec_pkg::prf_tag_t      dest_tag_o,
	output exec_pkg::rob_idx_t      rob_idx_o,
	output logic                    done_o
);

	localparam int CHUNK = (64 + MUL_STAGES - 1) / MUL_STAGES; // multiplier bits per stage.
	localparam exec_pkg::word_t CHUNK_MASK = (64'd1 << CHUNK) - 64'd1;

	exec_pkg::word_t opb;
	logic valid_q [MUL_STAGES];
	exec_pkg::word_t acc_q [MUL_STAGES]; // running partial sum.
	exec_pkg::prf_tag_t tag_q [MUL_STAGES];
	exec_pkg::rob_idx_t rob_q [MUL_STAGES];
	exec_pkg::word_t a_q [MUL_STAGES-1]; // operands, not needed after the last stage.
	exec_pkg::word_t b_q [MUL_STAGES-1];

	// partial products of one multiplier slice, already shifted into place
	function automatic exec_pkg::word_t slice_product(input exec_pkg::word_t a,
			input exec_pkg::word_t b, input int s);
		exec_pkg::word_t slice;
		slice = (b >> (s * CHUNK)) & CHUNK_MASK;
		return (a * slice) << (s * CHUNK);
	endfunction

	assign opb = inst_i[exec_pkg::LIT_FLAG_BIT] ?
		exec_pkg::word_t'(inst_i[exec_pkg::LIT_MSB:exec_pkg::LIT_LSB]) : opb_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < MUL_STAGES; s++) valid_q[s] <= 1'b0;
		end else begin
			valid_q[0] <= start_i;
			for (int s = 1; s < MUL_STAGES; s++) valid_q[s] <= valid_q[s-1];
		end
	end

	always_ff @(posedge clk) begin
		acc_q[0] <= slice_product(opa_i, opb, 0);
		tag_q[0] <= dest_tag_i;
		rob_q[0] <= rob_idx_i;
		a_q[0] <= opa_i;
		b_q[0] <= opb;
		for (int s = 1; s < MUL_STAGES; s++) begin
			acc_q[s] <= acc_q[s-1] + slice_product(a_q[s-1], b_q[s-1], s);
			tag_q[s] <= tag_q[s-1];
			rob_q[s] <= rob_q[s-1];
		end
		for (int s = 1; s < MUL_STAGES - 1; s++) begin
			a_q[s] <= a_q[s-1];
			b_q[s] <= b_q[s-1];
		end
	end

	assign product_o = acc_q[MUL_STAGES-1];
	assign dest_tag_o = tag_q[MUL_STAGES-1];
	assign rob_idx_o = rob_q[MUL_STAGES-1];
	assign done_o = valid_q[MUL_STAGES-1];

endmodule

`default_nettype wire
